//--- hdl/rom_pkg.sv
// shared sdram word types, arbiter and slot state encodings, ready delay
package rom_pkg;

    // 22-bit word address on the sdram read port
    typedef logic [21:0] sdram_addr_t;

    // one sdram read returns a full 32-bit word
    typedef logic [31:0] sdram_data_t;

    // arbiter sequencing for one outstanding read
    typedef enum logic [1:0] {
        arb_idle      = 2'd0,   // nothing selected
        arb_wait_ack  = 2'd1,   // request raised, waiting for controller
        arb_wait_data = 2'd2    // accepted, waiting for data_rdy
    } arb_state_e;

    // tells whether the slot tag holds a real address
    typedef enum logic {
        slot_empty  = 1'b0,     // tag meaningless after reset
        slot_filled = 1'b1
    } slot_state_e;

    // cycles from leaving reset until ready goes high
    localparam int READY_DELAY = 4;

endpackage

//--- hdl/rom_slot.sv
// rom_slot: one read-only client slot with offset address and one-word cache
`timescale 1ns/10ps

module rom_slot #(
    parameter int                   DW     = 8,     // 8, 16 or 32
    parameter int                   AW     = 12,
    parameter rom_pkg::sdram_addr_t OFFSET = '0     // region start, in words
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [AW-1:0]        addr,
    input  logic                 cs,
    input  logic                 sel,
    input  rom_pkg::sdram_data_t data_read,
    input  logic                 data_rdy,
    output logic [DW-1:0]        dout,
    output logic                 ok,
    output logic                 req,
    output rom_pkg::sdram_addr_t sdram_addr
);

    // address bits below the word boundary
    localparam int SHIFT = (DW == 8) ? 2 : ((DW == 16) ? 1 : 0);
    localparam int LW    = (SHIFT > 0) ? SHIFT : 1;

    rom_pkg::slot_state_e state;
    rom_pkg::sdram_addr_t word_addr;
    rom_pkg::sdram_addr_t tag;
    rom_pkg::sdram_data_t cache_data;
    rom_pkg::sdram_data_t src_word;
    rom_pkg::sdram_data_t lane_word;
    logic [LW-1:0]        lane;
    logic                 hit;
    logic                 fill;
    logic                 give;

    // word address inside this slot's region
    assign word_addr = OFFSET + rom_pkg::sdram_addr_t'(addr >> SHIFT);

    // lane index, always zero for 32-bit clients
    assign lane = (SHIFT > 0) ? addr[LW-1:0] : '0;

    assign fill = sel & data_rdy;   // our read is coming back

    assign hit  = (state == rom_pkg::slot_filled) && (tag == word_addr);

    // keep asking until the word is cached
    assign req        = cs & ~hit;
    assign sdram_addr = word_addr;

    // fresh data bypasses the cache so ok follows data_rdy by one cycle
    assign src_word  = fill ? data_read : cache_data;
    assign lane_word = src_word >> (DW * lane);   // little-endian lanes
    assign give      = cs & (hit | fill);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rom_pkg::slot_empty;
        end else if (fill) begin
            state <= rom_pkg::slot_filled;
        end
    end

    // cached word and its tag
    always_ff @(posedge clk) begin
        if (fill) begin
            cache_data <= data_read;
            tag        <= word_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ok <= 1'b0;
        end else begin
            ok <= give;
        end
    end

    // output lane registered together with ok
    always_ff @(posedge clk) begin
        if (give) begin
            dout <= lane_word[DW-1:0];
        end
    end

endmodule

//--- hdl/rom_arbiter.sv
// rom_arbiter: fixed-priority slot selection, sdram read request, refresh and ready
`timescale 1ns/10ps

module rom_arbiter #(
    parameter int NUM_SLOTS = 3
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  vblank,
    input  logic                                  downloading,
    input  logic                                  loop_rst,
    input  logic [NUM_SLOTS-1:0]                  req,
    input  rom_pkg::sdram_addr_t [NUM_SLOTS-1:0]  slot_addr,
    output logic [NUM_SLOTS-1:0]                  sel,
    input  logic                                  sdram_ack,
    input  logic                                  data_rdy,
    output logic                                  sdram_req,
    output rom_pkg::sdram_addr_t                  sdram_addr,
    output logic                                  refresh_en,
    output logic                                  ready
);

    localparam int CW = $clog2(rom_pkg::READY_DELAY + 1);

    rom_pkg::arb_state_e  state;
    rom_pkg::arb_state_e  state_next;
    logic [NUM_SLOTS-1:0] active;
    logic [NUM_SLOTS-1:0] pick;
    rom_pkg::sdram_addr_t pick_addr;
    logic                 hold;
    logic                 can_sel;
    logic [CW-1:0]        ready_cnt;

    assign hold = loop_rst | downloading;   // keeps everything in reset state

    // the slot being served still has req up until its cache fills
    assign active = req & ~sel;

    // lowest index wins, so scan downwards and let the last hit stay
    always_comb begin
        pick      = '0;
        pick_addr = slot_addr[0];
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (active[i]) begin
                pick      = '0;
                pick[i]   = 1'b1;
                pick_addr = slot_addr[i];
            end
        end
    end

    // new pick when idle or when the current read completes
    assign can_sel = (state == rom_pkg::arb_idle) ||
                     (state == rom_pkg::arb_wait_data && data_rdy);

    always_comb begin
        state_next = state;
        case (state)
            rom_pkg::arb_idle: begin
                if (|active) state_next = rom_pkg::arb_wait_ack;
            end
            rom_pkg::arb_wait_ack: begin
                if (sdram_ack) state_next = rom_pkg::arb_wait_data;
            end
            rom_pkg::arb_wait_data: begin
                if (data_rdy) begin   // back to back if another slot waits
                    state_next = (|active) ? rom_pkg::arb_wait_ack : rom_pkg::arb_idle;
                end
            end
            default: state_next = rom_pkg::arb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rom_pkg::arb_idle;
            sel        <= '0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b1;
        end else if (hold) begin
            state      <= rom_pkg::arb_idle;
            sel        <= '0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b1;
        end else begin
            state      <= state_next;
            refresh_en <= vblank && (state_next == rom_pkg::arb_idle);
            if (can_sel) begin
                sel       <= pick;
                sdram_req <= |active;
            end else if (state == rom_pkg::arb_wait_ack && sdram_ack) begin
                sdram_req <= 1'b0;   // drops the cycle after ack
            end
        end
    end

    // address latched with the selection, stable while the request is up
    always_ff @(posedge clk) begin
        if (!hold && can_sel && |active) begin
            sdram_addr <= pick_addr;
        end
    end

    // ready comes READY_DELAY cycles after the last reset source goes away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
        end else if (hold) begin
            ready_cnt <= '0;
            ready     <= 1'b0;
        end else if (!ready) begin
            ready_cnt <= ready_cnt + 1'b1;
            ready     <= (ready_cnt == CW'(rom_pkg::READY_DELAY - 1));
        end
    end

endmodule

//--- hdl/rom_top.sv
// rom_top: three rom_slot clients sharing one sdram read port through rom_arbiter
`timescale 1ns/10ps

module rom_top #(
    parameter int                   SLOT0_DW     = 8,
    parameter int                   SLOT1_DW     = 16,
    parameter int                   SLOT2_DW     = 32,
    parameter int                   SLOT0_AW     = 14,   // 16 kB in bytes
    parameter int                   SLOT1_AW     = 13,   // 16 kB in halfwords
    parameter int                   SLOT2_AW     = 12,   // 16 kB in words
    parameter rom_pkg::sdram_addr_t SLOT0_OFFSET = 22'h0,
    parameter rom_pkg::sdram_addr_t SLOT1_OFFSET = 22'h1000,
    parameter rom_pkg::sdram_addr_t SLOT2_OFFSET = 22'h2000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic [SLOT0_AW-1:0]  slot0_addr,
    input  logic                 slot0_cs,
    output logic [SLOT0_DW-1:0]  slot0_dout,
    output logic                 slot0_ok,

    input  logic [SLOT1_AW-1:0]  slot1_addr,
    input  logic                 slot1_cs,
    output logic [SLOT1_DW-1:0]  slot1_dout,
    output logic                 slot1_ok,

    input  logic [SLOT2_AW-1:0]  slot2_addr,
    input  logic                 slot2_cs,
    output logic [SLOT2_DW-1:0]  slot2_dout,
    output logic                 slot2_ok,

    input  logic                 vblank,
    input  logic                 downloading,
    input  logic                 loop_rst,

    // sdram controller side
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  rom_pkg::sdram_data_t data_read,
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    output logic                 refresh_en,
    output logic                 ready
);

    logic [2:0]                 req;
    logic [2:0]                 sel;          // one-hot grant
    rom_pkg::sdram_addr_t [2:0] slot_addr;    // per-slot word addresses

    rom_slot #(
        .DW     (SLOT0_DW),
        .AW     (SLOT0_AW),
        .OFFSET (SLOT0_OFFSET)
    ) u_slot0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (slot0_addr),
        .cs         (slot0_cs),
        .sel        (sel[0]),
        .data_read  (data_read),
        .data_rdy   (data_rdy),
        .dout       (slot0_dout),
        .ok         (slot0_ok),
        .req        (req[0]),
        .sdram_addr (slot_addr[0])
    );

    rom_slot #(
        .DW     (SLOT1_DW),
        .AW     (SLOT1_AW),
        .OFFSET (SLOT1_OFFSET)
    ) u_slot1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (slot1_addr),
        .cs         (slot1_cs),
        .sel        (sel[1]),
        .data_read  (data_read),
        .data_rdy   (data_rdy),
        .dout       (slot1_dout),
        .ok         (slot1_ok),
        .req        (req[1]),
        .sdram_addr (slot_addr[1])
    );

    rom_slot #(
        .DW     (SLOT2_DW),
        .AW     (SLOT2_AW),
        .OFFSET (SLOT2_OFFSET)
    ) u_slot2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (slot2_addr),
        .cs         (slot2_cs),
        .sel        (sel[2]),
        .data_read  (data_read),
        .data_rdy   (data_rdy),
        .dout       (slot2_dout),
        .ok         (slot2_ok),
        .req        (req[2]),
        .sdram_addr (slot_addr[2])
    );

    // slot 0 has the highest priority
    rom_arbiter #(
        .NUM_SLOTS (3)
    ) u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .req         (req),
        .slot_addr   (slot_addr),
        .sel         (sel),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

endmodule

//--- sim/rom_checker.sv
// rom_checker: bound assertions on the sdram request protocol, grant and slot ok
`timescale 1ns/10ps

module rom_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 loop_rst,
    input logic                 downloading,
    input logic                 sdram_req,
    input logic                 sdram_ack,
    input rom_pkg::sdram_addr_t sdram_addr,
    input logic [2:0]           sel,
    input logic                 slot0_cs,
    input logic                 slot0_ok,
    input logic                 slot1_cs,
    input logic                 slot1_ok,
    input logic                 slot2_cs,
    input logic                 slot2_ok
);

    int fails = 0;   // failed assertions so far

    // request holds with a fixed address until the controller acks
    req_hold: assert property (@(posedge clk) disable iff (!rst_n || loop_rst || downloading)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $error("sdram_req dropped or sdram_addr moved before ack");
            fails++;
        end

    sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel))
        else begin
            $error("sel has more than one bit set");
            fails++;
        end

    ok0_cs: assert property (@(posedge clk) disable iff (!rst_n) $rose(slot0_ok) |-> $past(slot0_cs))
        else begin
            $error("slot0_ok rose without cs");
            fails++;
        end
    ok1_cs: assert property (@(posedge clk) disable iff (!rst_n) $rose(slot1_ok) |-> $past(slot1_cs))
        else begin
            $error("slot1_ok rose without cs");
            fails++;
        end
    ok2_cs: assert property (@(posedge clk) disable iff (!rst_n) $rose(slot2_ok) |-> $past(slot2_cs))
        else begin
            $error("slot2_ok rose without cs");
            fails++;
        end

endmodule

//--- sim/rom_monitor.sv
// rom_monitor: expected slot data, request counting, ready and refresh rules, test results
`timescale 1ns/10ps

module rom_monitor (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 loop_rst,
    input logic                 downloading,
    input logic [13:0]          slot0_addr,
    input logic [7:0]           slot0_dout,
    input logic                 slot0_ok,
    input logic [12:0]          slot1_addr,
    input logic [15:0]          slot1_dout,
    input logic                 slot1_ok,
    input logic [11:0]          slot2_addr,
    input logic [31:0]          slot2_dout,
    input logic                 slot2_ok,
    input logic                 sdram_req,
    input rom_pkg::sdram_addr_t sdram_addr,
    input logic                 refresh_en,
    input logic                 ready
);

    int                   errors = 0;
    int                   tests = 0;
    int                   test_err = 0;
    int                   cyc = 0;
    int                   req_cnt = 0;
    int                   quiet = 0;     // edges since the last reset source
    int                   first_ok[3];
    string                cur_name = "reset";
    logic                 hold_q = 1'b1;
    logic                 req_prev = 1'b0;
    logic [13:0]          a0_q;
    logic [12:0]          a1_q;
    logic [11:0]          a2_q;
    rom_pkg::sdram_addr_t w[3];
    rom_pkg::sdram_addr_t req_q[$];

    // controller content rule
    function automatic logic [31:0] sdram_word(input rom_pkg::sdram_addr_t a);
        return {a[15:0] ^ 16'ha5c3, ~a[15:0]};
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
        errors++;
        test_err++;
    endtask

    task automatic fail(input string msg);
        $display("Error in %s: %s", cur_name, msg);
        errors++;
        test_err++;
    endtask

    always @(posedge clk) begin
        cyc++;
        a0_q = slot0_addr;
        a1_q = slot1_addr;
        a2_q = slot2_addr;
        hold_q = !rst_n || loop_rst || downloading;
        quiet = hold_q ? 0 : ((quiet < 100) ? quiet + 1 : quiet);
    end

    always @(negedge clk) begin
        w[0] = 22'h0 + 22'(a0_q >> 2);       // region offsets of the three slots
        w[1] = 22'h1000 + 22'(a1_q >> 1);
        w[2] = 22'h2000 + 22'(a2_q);
        if (ready !== (quiet >= rom_pkg::READY_DELAY))
            fail($sformatf("ready is %b after %0d quiet cycles", ready, quiet));
        if (sdram_req && refresh_en) fail("refresh_en high during a request");
        if (rst_n && hold_q && (!refresh_en || sdram_req))
            fail("arbiter not held idle with refresh during reset hold");
        if (sdram_req && !req_prev) begin
            req_cnt++;
            req_q.push_back(sdram_addr);
        end
        req_prev = sdram_req;
        if (slot0_ok) begin
            if (first_ok[0] == 0) first_ok[0] = cyc;
            if (slot0_dout !== 8'(sdram_word(w[0]) >> (8 * a0_q[1:0])))
                mismatch("slot0 dout", 8'(sdram_word(w[0]) >> (8 * a0_q[1:0])), slot0_dout);
        end
        if (slot1_ok) begin
            if (first_ok[1] == 0) first_ok[1] = cyc;
            if (slot1_dout !== 16'(sdram_word(w[1]) >> (16 * a1_q[0])))
                mismatch("slot1 dout", 16'(sdram_word(w[1]) >> (16 * a1_q[0])), slot1_dout);
        end
        if (slot2_ok) begin
            if (first_ok[2] == 0) first_ok[2] = cyc;
            if (slot2_dout !== sdram_word(w[2])) mismatch("slot2 dout", sdram_word(w[2]), slot2_dout);
        end
    end

    task automatic begin_test(input string name);
        cur_name = name;
        test_err = 0;
        cyc = 0;
        req_cnt = 0;
        req_q.delete();
        first_ok = '{0, 0, 0};
    endtask

    task automatic check_idle_refresh();
        if (refresh_en !== 1'b1) fail("refresh_en low while idle in vblank");
    endtask

    // exp_reqs below zero skips the request count
    task automatic end_test(input int exp_reqs, input bit order);
        if (exp_reqs >= 0 && req_cnt != exp_reqs) mismatch("request count", exp_reqs, req_cnt);
        for (int i = 0; i < 3; i++) begin
            if (exp_reqs == 0 && first_ok[i] > 1) mismatch("hit latency", 1, first_ok[i]);
        end
        if (order && req_q.size() != 3) fail("expected three requests in slot order");
        else if (order) begin
            for (int i = 0; i < 3; i++) begin
                if (req_q[i] !== w[i]) mismatch($sformatf("request %0d addr", i), w[i], req_q[i]);
            end
        end
        tests++;
        $display("%-14s %s", cur_name, (test_err == 0) ? "ok" : $sformatf("%0d errors", test_err));
    endtask

endmodule

//--- sim/rom_tb.sv
// rom_tb: clock, reset, sdram read model, stimulus table, timeout
`timescale 1ns/10ps

module rom_tb;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic [13:0]          slot0_addr = '0;
    logic [12:0]          slot1_addr = '0;
    logic [11:0]          slot2_addr = '0;
    logic                 slot0_cs = 1'b0;
    logic                 slot1_cs = 1'b0;
    logic                 slot2_cs = 1'b0;
    logic [7:0]           slot0_dout;
    logic [15:0]          slot1_dout;
    logic [31:0]          slot2_dout;
    logic                 slot0_ok;
    logic                 slot1_ok;
    logic                 slot2_ok;
    logic                 vblank = 1'b0;
    logic                 downloading = 1'b0;
    logic                 loop_rst = 1'b0;
    logic                 sdram_ack = 1'b0;
    logic                 data_rdy = 1'b0;
    rom_pkg::sdram_data_t data_read = '0;
    logic                 sdram_req;
    rom_pkg::sdram_addr_t sdram_addr;
    logic                 refresh_en;
    logic                 ready;

    // stimulus table, one row per test
    string       t_name[$];
    logic [2:0]  t_mask[$];
    logic [13:0] t_a0[$];
    logic [12:0] t_a1[$];
    logic [11:0] t_a2[$];
    logic        t_vb[$];
    int          t_reqs[$];
    bit          t_order[$];
    bit          t_slow[$];

    bit          slow = 0;    // stretches ack and data delays
    int          cycles = 0;
    int          limit = 1000;
    int unsigned seed_val;

    always #5 clk = ~clk;

    rom_top i_dut (.*);

    rom_monitor u_mon (.*);

    bind rom_top rom_checker u_chk (.*);

    // sdram controller model
    always begin
        rom_pkg::sdram_addr_t a;
        @(negedge clk);
        if (sdram_req === 1'b1) begin
            a = sdram_addr;
            repeat ($urandom_range(3, 0) + (slow ? $urandom_range(6, 0) : 0)) @(negedge clk);
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
            repeat ($urandom_range(4, 1) + (slow ? $urandom_range(6, 0) : 0)) @(negedge clk);
            data_read = {a[15:0] ^ 16'ha5c3, ~a[15:0]};
            data_rdy = 1'b1;
            @(negedge clk);
            data_rdy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: a test got no response within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic add_row(input string name, input logic [2:0] mask, input logic [13:0] a0,
                           input logic [12:0] a1, input logic [11:0] a2, input logic vb,
                           input int reqs, input bit order, input bit sl);
        t_name.push_back(name);
        t_mask.push_back(mask);
        t_a0.push_back(a0);
        t_a1.push_back(a1);
        t_a2.push_back(a2);
        t_vb.push_back(vb);
        t_reqs.push_back(reqs);
        t_order.push_back(order);
        t_slow.push_back(sl);
    endtask

    task automatic apply_row(input int i);
        logic [2:0] seen;
        seen = '0;
        slot0_addr = t_a0[i];
        slot1_addr = t_a1[i];
        slot2_addr = t_a2[i];
        {slot2_cs, slot1_cs, slot0_cs} = t_mask[i];
        vblank = t_vb[i];
        slow = t_slow[i];
        u_mon.begin_test(t_name[i]);
        while ((seen & t_mask[i]) != t_mask[i]) begin
            @(negedge clk);
            seen |= {slot2_ok, slot1_ok, slot0_ok};
        end
        {slot2_cs, slot1_cs, slot0_cs} = 3'b000;
        repeat (2) @(negedge clk);
        u_mon.end_test(t_reqs[i], t_order[i]);
    endtask

    initial begin
        seed_val = $urandom(32'he87);
        add_row("miss_s0",   3'b001, 14'h0123, 13'h0,    12'h0,    1'b0, 1, 0, 0);
        add_row("miss_s1",   3'b010, 14'h0123, 13'h0457, 12'h0,    1'b0, 1, 0, 0);
        add_row("miss_s2",   3'b100, 14'h0123, 13'h0457, 12'h0abc, 1'b0, 1, 0, 0);
        add_row("hit_s0",    3'b001, 14'h0122, 13'h0457, 12'h0abc, 1'b0, 0, 0, 0);
        add_row("hit_s1",    3'b010, 14'h0122, 13'h0456, 12'h0abc, 1'b0, 0, 0, 0);
        add_row("all_miss",  3'b111, 14'h2001, 13'h0800, 12'h0100, 1'b0, 3, 1, 0);
        add_row("vb_miss",   3'b111, 14'h3ffe, 13'h1fff, 12'hfff,  1'b1, 3, 1, 0);
        add_row("rehit_all", 3'b111, 14'h3fff, 13'h1ffe, 12'hfff,  1'b0, 0, 0, 0);
        add_row("slow_a",    3'b111, 14'h1555, 13'h0aaa, 12'h555,  1'b0, 3, 1, 1);
        add_row("slow_b",    3'b111, 14'h0a0b, 13'h1234, 12'h321,  1'b1, 3, 1, 1);
        limit = 10 + 20 * t_name.size() + 60 + 40;    // reset, rows, slow rows, hold phases

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (8) @(negedge clk);
        for (int i = 0; i < t_name.size(); i++) apply_row(i);

        vblank = 1'b1;
        u_mon.begin_test("idle_refresh");
        repeat (3) @(negedge clk);
        u_mon.check_idle_refresh();
        u_mon.end_test(0, 0);

        u_mon.begin_test("downloading");
        vblank = 1'b0;    // refresh only from the hold
        downloading = 1'b1;
        repeat (6) @(negedge clk);
        downloading = 1'b0;
        repeat (6) @(negedge clk);
        u_mon.end_test(0, 0);

        u_mon.begin_test("loop_rst");
        loop_rst = 1'b1;
        repeat (2) @(negedge clk);
        loop_rst = 1'b0;
        repeat (8) @(negedge clk);
        u_mon.end_test(0, 0);

        $display("tests %0d, errors %0d", u_mon.tests, u_mon.errors + i_dut.u_chk.fails);
        if (u_mon.errors + i_dut.u_chk.fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/rom_pkg.sv
hdl/rom_slot.sv
hdl/rom_arbiter.sv
hdl/rom_top.sv
sim/rom_checker.sv
sim/rom_monitor.sv
sim/rom_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rom_tb
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)
